/* tb.f */
+incdir+common
common/mem_bridge_pkg.sv
common/rw_if.sv
common/axi_if.sv
hw/rw_arbiter.sv
axi_master/axi_master.sv
hw/axi_sram_slave.sv
hw/mem_subsystem_top.sv
verif/mem_subsystem_assertions.sv
verif/mem_subsystem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mem_subsystem_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# fails on the fail message, or when the run stops before its summary
sim: build
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/mem_subsystem_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_bridge_params.svh"

module mem_subsystem_tb;
    import mem_bridge_pkg::*;

    localparam int unsigned SEED    = 54;
    localparam int unsigned TIMEOUT = 200;
    localparam int unsigned N_OPS   = 40;
    localparam int unsigned DATA_W  = `DATA_WIDTH;
    localparam int unsigned STRB_W  = `STRB_WIDTH;
    localparam int unsigned IDX_W   = $clog2(`MEM_DEPTH);

    logic                   clock = 1'b0;
    logic                   reset_n;
    logic                   fetch_valid_i;
    logic [`ADDR_WIDTH-1:0] fetch_addr_i;
    logic                   fetch_ready_o;
    logic [DATA_W-1:0]      fetch_rdata_o;
    logic                   fetch_err_o;
    logic                   data_valid_i;
    rw_req_e                data_req_i;
    logic [`ADDR_WIDTH-1:0] data_addr_i;
    logic [DATA_W-1:0]      data_wdata_i;
    logic [STRB_W-1:0]      data_strb_i;
    logic                   data_ready_o;
    logic [DATA_W-1:0]      data_rdata_o;
    logic                   data_err_o;

    // reference memory, starts cleared like the slave
    logic [DATA_W-1:0] model [`MEM_DEPTH];
    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned tests_run = 0;
    int unsigned test_errors;
    int unsigned test_checks;
    time         data_done_t;
    time         fetch_done_t;

    always #20 clock = ~clock;

    mem_subsystem_top mem_subsystem_top_inst (
        .clock         (clock),
        .reset_n       (reset_n),
        .fetch_valid_i (fetch_valid_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_ready_o (fetch_ready_o),
        .fetch_rdata_o (fetch_rdata_o),
        .fetch_err_o   (fetch_err_o),
        .data_valid_i  (data_valid_i),
        .data_req_i    (data_req_i),
        .data_addr_i   (data_addr_i),
        .data_wdata_i  (data_wdata_i),
        .data_strb_i   (data_strb_i),
        .data_ready_o  (data_ready_o),
        .data_rdata_o  (data_rdata_o),
        .data_err_o    (data_err_o)
    );

    // word aligned addresses below MEM_DEPTH words are backed by memory
    function automatic logic addr_ok(input logic [`ADDR_WIDTH-1:0] addr);
        return addr < `ADDR_WIDTH'(`MEM_DEPTH * STRB_W);
    endfunction

    // mode 0 in range, 1 mixed (about one in eight outside), 2 outside
    function automatic logic [`ADDR_WIDTH-1:0] pick_addr(input int mode);
        int unsigned word;
        word = $urandom_range(`MEM_DEPTH - 1, 0);
        if (mode == 2 || (mode == 1 && $urandom_range(7, 0) == 0)) begin
            word += `MEM_DEPTH * $urandom_range(3, 1);
        end
        return `ADDR_WIDTH'(word * STRB_W);
    endfunction

    function automatic logic [DATA_W-1:0] model_read(input logic [`ADDR_WIDTH-1:0] addr);
        if (!addr_ok(addr)) return '0;
        return model[addr[3 +: IDX_W]];
    endfunction

    // lane by lane under the strobe
    task automatic model_write(input logic [`ADDR_WIDTH-1:0] addr,
                               input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb);
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) model[addr[3 +: IDX_W]][b*8 +: 8] = wdata[b*8 +: 8];
        end
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] got);
        checks++;
        test_checks++;
        assert (got === exp) else begin
            $display("ERR t=%0t %s expected=%h actual=%h", $time, name, exp, got);
            errors++;
            test_errors++;
        end
    endtask

    task automatic give_up(input string port);
        $display("timeout: %s port saw no ready pulse within %0d cycles", port, TIMEOUT);
        $display("tests=%0d checks=%0d errors=%0d", tests_run, checks, errors + 1);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic data_access(input rw_req_e kind, input logic [`ADDR_WIDTH-1:0] addr,
                               input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb,
                               output logic [DATA_W-1:0] rdata, output logic err);
        int unsigned n;
        @(posedge clock);
        data_valid_i <= 1'b1;
        data_req_i   <= kind;
        data_addr_i  <= addr;
        data_wdata_i <= wdata;
        data_strb_i  <= strb;
        n = 0;
        // ready is a one-cycle pulse, sampled mid-cycle
        do begin
            @(negedge clock);
            n++;
            if (n > TIMEOUT) give_up("data");
        end while (!data_ready_o);
        rdata       = data_rdata_o;
        err         = data_err_o;
        data_done_t = $time;
        @(posedge clock);
        data_valid_i <= 1'b0;
    endtask

    task automatic fetch_read_check(input logic [`ADDR_WIDTH-1:0] addr);
        int unsigned n;
        @(posedge clock);
        fetch_valid_i <= 1'b1;
        fetch_addr_i  <= addr;
        n = 0;
        do begin
            @(negedge clock);
            n++;
            if (n > TIMEOUT) give_up("fetch");
        end while (!fetch_ready_o);
        fetch_done_t = $time;
        check_value("fetch_rdata_o", model_read(addr), fetch_rdata_o);
        check_value("fetch_err_o", DATA_W'(!addr_ok(addr)), DATA_W'(fetch_err_o));
        @(posedge clock);
        fetch_valid_i <= 1'b0;
    endtask

    task automatic data_write(input logic [`ADDR_WIDTH-1:0] addr);
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
        logic [DATA_W-1:0] rdata;
        logic              err;
        wdata = {$urandom, $urandom};
        strb  = STRB_W'($urandom);
        data_access(REQ_WRITE, addr, wdata, strb, rdata, err);
        check_value("data_err_o", DATA_W'(!addr_ok(addr)), DATA_W'(err));
        // writes outside the array are dropped
        if (addr_ok(addr)) model_write(addr, wdata, strb);
    endtask

    task automatic data_read_check(input logic [`ADDR_WIDTH-1:0] addr);
        logic [DATA_W-1:0] rdata;
        logic              err;
        data_access(REQ_READ, addr, '0, '0, rdata, err);
        check_value("data_rdata_o", model_read(addr), rdata);
        check_value("data_err_o", DATA_W'(!addr_ok(addr)), DATA_W'(err));
    endtask

    task automatic start_test();
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %0d %s: %0d checks, %0d errors", tests_run, name, test_checks,
                 test_errors);
    endtask

    initial begin
        logic [`ADDR_WIDTH-1:0] a;
        logic [`ADDR_WIDTH-1:0] pool [4];
        void'($urandom(SEED));
        for (int i = 0; i < `MEM_DEPTH; i++) model[i] = '0;
        reset_n       <= 1'b0;
        fetch_valid_i <= 1'b0;
        fetch_addr_i  <= '0;
        data_valid_i  <= 1'b0;
        data_req_i    <= REQ_READ;
        data_addr_i   <= '0;
        data_wdata_i  <= '0;
        data_strb_i   <= '0;
        repeat (5) @(posedge clock);
        reset_n <= 1'b1;

        // quiet ports after reset, memory reads back zero
        start_test();
        repeat (10) begin
            @(negedge clock);
            check_value("fetch_ready_o", '0, DATA_W'(fetch_ready_o));
            check_value("data_ready_o", '0, DATA_W'(data_ready_o));
        end
        repeat (8) data_read_check(pick_addr(0));
        repeat (4) fetch_read_check(pick_addr(0));
        end_test("idle after reset");

        // strobed writes, second write keeps unstrobed bytes of the first
        start_test();
        repeat (N_OPS) begin
            a = pick_addr(1);
            data_write(a);
            data_write(a);
            data_read_check(a);
        end
        end_test("strobed data writes");

        // fetch reads racing data writes over a small address pool
        start_test();
        for (int i = 0; i < 4; i++) pool[i] = pick_addr(0);
        fork
            repeat (N_OPS) data_write(pool[$urandom_range(3, 0)]);
            repeat (N_OPS) fetch_read_check(pool[$urandom_range(3, 0)]);
        join
        end_test("fetch reads with data writes");

        // same-cycle requests, data port must finish first
        start_test();
        repeat (8) begin
            a = pick_addr(0);
            fork
                data_write(a);
                fetch_read_check(a);
            join
            checks++;
            test_checks++;
            assert (data_done_t < fetch_done_t) else begin
                $display("data port did not finish before fetch port at t=%0t", $time);
                errors++;
                test_errors++;
            end
        end
        end_test("data priority");

        // outside the array, then the aliased word shows nothing was written
        start_test();
        repeat (16) begin
            a = pick_addr(2);
            data_write(a);
            data_read_check(a);
            fetch_read_check(a);
            data_read_check(`ADDR_WIDTH'({a[3 +: IDX_W], 3'b000}));
        end
        end_test("out of range");

        $display("tests=%0d checks=%0d errors=%0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/mem_subsystem_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_bridge_params.svh"

module mem_subsystem_assertions (
    input wire logic                    clock,
    input wire logic                    reset_n,
    input wire logic                    aw_valid,
    input wire logic                    aw_ready,
    input wire logic [`ADDR_WIDTH-1:0]  aw_addr,
    input wire logic                    w_valid,
    input wire logic                    w_ready,
    input wire logic [`DATA_WIDTH-1:0]  w_data,
    input wire logic [`STRB_WIDTH-1:0]  w_strb,
    input wire logic                    b_valid,
    input wire logic                    b_ready,
    input wire logic                    ar_valid,
    input wire logic                    ar_ready,
    input wire logic [`ADDR_WIDTH-1:0]  ar_addr,
    input wire mem_bridge_pkg::req_id_t ar_id,
    input wire logic                    r_valid,
    input wire logic                    r_ready,
    input wire logic                    r_last,
    input wire mem_bridge_pkg::req_id_t r_id,
    input wire logic                    rw_ready
);
    import mem_bridge_pkg::*;

    // transactions open on the bus
    logic    wr_open;
    logic    rd_open;
    // id of the pending read
    req_id_t rd_id;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            wr_open <= 1'b0;
            rd_open <= 1'b0;
            rd_id   <= ID_FETCH;
        end else begin
            if (aw_valid && aw_ready) begin
                wr_open <= 1'b1;
            end else if (b_valid && b_ready) begin
                wr_open <= 1'b0;
            end
            if (ar_valid && ar_ready) begin
                rd_open <= 1'b1;
                rd_id   <= ar_id;
            end else if (r_valid && r_ready && r_last) begin
                rd_open <= 1'b0;
            end
        end
    end

    aw_hold: assert property (@(posedge clock) disable iff (!reset_n)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
        else $error("AW dropped or changed before its handshake");

    w_hold: assert property (@(posedge clock) disable iff (!reset_n)
        w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_strb))
        else $error("W dropped or changed before its handshake");

    ar_hold: assert property (@(posedge clock) disable iff (!reset_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_id))
        else $error("AR dropped or changed before its handshake");

    // slave must echo the AR id
    r_id_match: assert property (@(posedge clock) disable iff (!reset_n)
        r_valid |-> rd_open && (r_id == rd_id))
        else $error("R id does not match the pending AR id");

    b_ready_open: assert property (@(posedge clock) disable iff (!reset_n)
        b_ready |-> wr_open)
        else $error("B ready high with no write open");

    r_ready_open: assert property (@(posedge clock) disable iff (!reset_n)
        r_ready |-> rd_open)
        else $error("R ready high with no read open");

    ready_pulse: assert property (@(posedge clock) disable iff (!reset_n)
        rw_ready |=> !rw_ready)
        else $error("rw ready high on two cycles in a row");

endmodule

bind axi_master mem_subsystem_assertions mem_subsystem_assertions_inst (
    .clock    (clock),
    .reset_n  (reset_n),
    .aw_valid (axi.aw_valid),
    .aw_ready (axi.aw_ready),
    .aw_addr  (axi.aw_addr),
    .w_valid  (axi.w_valid),
    .w_ready  (axi.w_ready),
    .w_data   (axi.w_data),
    .w_strb   (axi.w_strb),
    .b_valid  (axi.b_valid),
    .b_ready  (axi.b_ready),
    .ar_valid (axi.ar_valid),
    .ar_ready (axi.ar_ready),
    .ar_addr  (axi.ar_addr),
    .ar_id    (axi.ar_id),
    .r_valid  (axi.r_valid),
    .r_ready  (axi.r_ready),
    .r_last   (axi.r_last),
    .r_id     (axi.r_id),
    .rw_ready (rw.ready)
);

`default_nettype wire

/* hw/mem_subsystem_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_bridge_params.svh"

module mem_subsystem_top (
    input  wire logic                    clock,
    input  wire logic                    reset_n,
    // fetch port
    input  wire logic                    fetch_valid_i,
    input  wire logic [`ADDR_WIDTH-1:0]  fetch_addr_i,
    output logic                         fetch_ready_o,
    output logic [`DATA_WIDTH-1:0]       fetch_rdata_o,
    output logic                         fetch_err_o,
    // data port
    input  wire logic                    data_valid_i,
    input  wire mem_bridge_pkg::rw_req_e data_req_i,
    input  wire logic [`ADDR_WIDTH-1:0]  data_addr_i,
    input  wire logic [`DATA_WIDTH-1:0]  data_wdata_i,
    input  wire logic [`STRB_WIDTH-1:0]  data_strb_i,
    output logic                         data_ready_o,
    output logic [`DATA_WIDTH-1:0]       data_rdata_o,
    output logic                         data_err_o
);

    // arbiter to bridge
    rw_if  rw_bus ();
    // bridge to memory
    axi_if axi_bus ();

    rw_arbiter rw_arbiter_inst (
        .clock         (clock),
        .reset_n       (reset_n),
        .fetch_valid_i (fetch_valid_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_ready_o (fetch_ready_o),
        .fetch_rdata_o (fetch_rdata_o),
        .fetch_err_o   (fetch_err_o),
        .data_valid_i  (data_valid_i),
        .data_req_i    (data_req_i),
        .data_addr_i   (data_addr_i),
        .data_wdata_i  (data_wdata_i),
        .data_strb_i   (data_strb_i),
        .data_ready_o  (data_ready_o),
        .data_rdata_o  (data_rdata_o),
        .data_err_o    (data_err_o),
        .rw            (rw_bus.requester)
    );

    axi_master axi_master_inst (
        .clock   (clock),
        .reset_n (reset_n),
        .rw      (rw_bus.bridge),
        .axi     (axi_bus.master)
    );

    axi_sram_slave axi_sram_slave_inst (
        .clock   (clock),
        .reset_n (reset_n),
        .axi     (axi_bus.slave)
    );

endmodule

`default_nettype wire

/* hw/axi_sram_slave.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_bridge_params.svh"

module axi_sram_slave (
    input  wire logic clock,
    input  wire logic reset_n,
    axi_if.slave      axi
);
    import mem_bridge_pkg::*;

    localparam int unsigned IDX_W = $clog2(`MEM_DEPTH);
    localparam int unsigned OFF_W = $clog2(`STRB_WIDTH);
    localparam int unsigned CNT_W = $clog2(`READ_LATENCY + 1);
    localparam logic [`ADDR_WIDTH-1:0] MEM_BYTES = `ADDR_WIDTH'(`MEM_DEPTH * `STRB_WIDTH);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT,
        RD_RESP
    } rd_state_e;

    logic [`DATA_WIDTH-1:0] mem [`MEM_DEPTH];

    // write side
    logic                   aw_held;
    logic                   w_held;
    logic                   b_valid_q;
    axi_resp_e              b_resp_q;
    logic [`ADDR_WIDTH-1:0] aw_addr_q;
    logic [`DATA_WIDTH-1:0] w_data_q;
    logic [`STRB_WIDTH-1:0] w_strb_q;
    logic                   aw_hs;
    logic                   w_hs;
    logic                   wr_fire;
    logic                   wr_in_range;
    logic [`ADDR_WIDTH-1:0] wr_addr;
    logic [`DATA_WIDTH-1:0] wr_data;
    logic [`STRB_WIDTH-1:0] wr_strb;
    logic [IDX_W-1:0]       wr_idx;

    // read side
    rd_state_e              rd_state;
    logic [CNT_W-1:0]       rd_cnt;
    logic [`ADDR_WIDTH-1:0] ar_addr_q;
    req_id_t                ar_id_q;
    logic [`DATA_WIDTH-1:0] r_data_q;
    axi_resp_e              r_resp_q;
    logic                   ar_hs;
    logic                   rd_load;
    logic                   rd_in_range;
    logic [`ADDR_WIDTH-1:0] rd_addr;

    // word aligned and inside the array
    function automatic logic in_range(input logic [`ADDR_WIDTH-1:0] addr);
        return (addr[OFF_W-1:0] == '0) && (addr < MEM_BYTES);
    endfunction

    // AW and W taken in either order, one write in flight
    assign axi.aw_ready = ~aw_held & ~b_valid_q;
    assign axi.w_ready  = ~w_held & ~b_valid_q;
    assign aw_hs        = axi.aw_valid & axi.aw_ready;
    assign w_hs         = axi.w_valid & axi.w_ready;

    assign wr_addr     = aw_held ? aw_addr_q : axi.aw_addr;
    assign wr_data     = w_held ? w_data_q : axi.w_data;
    assign wr_strb     = w_held ? w_strb_q : axi.w_strb;
    assign wr_fire     = (aw_held | aw_hs) & (w_held | w_hs);
    assign wr_in_range = in_range(wr_addr);
    assign wr_idx      = wr_addr[OFF_W +: IDX_W];

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            aw_held   <= 1'b0;
            w_held    <= 1'b0;
            b_valid_q <= 1'b0;
        end else if (wr_fire) begin
            aw_held   <= 1'b0;
            w_held    <= 1'b0;
            b_valid_q <= 1'b1;
        end else begin
            if (aw_hs) aw_held <= 1'b1;
            if (w_hs) w_held <= 1'b1;
            // B held until the master takes it
            if (b_valid_q && axi.b_ready) b_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (aw_hs) aw_addr_q <= axi.aw_addr;
        if (w_hs) begin
            w_data_q <= axi.w_data;
            w_strb_q <= axi.w_strb;
        end
        if (wr_fire) b_resp_q <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
    end

    // array cleared on reset, lane writes otherwise
    // out-of-range writes are dropped
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            for (int i = 0; i < `MEM_DEPTH; i++) mem[i] <= '0;
        end else if (wr_fire && wr_in_range) begin
            for (int b = 0; b < `STRB_WIDTH; b++) begin
                if (wr_strb[b]) mem[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
            end
        end
    end

    assign axi.b_valid = b_valid_q;
    assign axi.b_resp  = b_resp_q;

    // read side, fixed latency from the AR handshake
    assign axi.ar_ready = (rd_state == RD_IDLE);
    assign ar_hs        = axi.ar_valid & axi.ar_ready;
    assign rd_addr      = (rd_state == RD_IDLE) ? axi.ar_addr : ar_addr_q;
    assign rd_in_range  = in_range(rd_addr);
    // word loaded on the cycle before R valid
    assign rd_load      = (ar_hs && (`READ_LATENCY <= 1)) ||
                          ((rd_state == RD_WAIT) && (rd_cnt == CNT_W'(1)));

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            rd_state <= RD_IDLE;
            rd_cnt   <= '0;
        end else begin
            case (rd_state)
                RD_IDLE: if (ar_hs) begin
                    rd_cnt <= CNT_W'(`READ_LATENCY - 1);
                    if (`READ_LATENCY <= 1) rd_state <= RD_RESP;
                    else rd_state <= RD_WAIT;
                end
                RD_WAIT: if (rd_cnt == CNT_W'(1)) rd_state <= RD_RESP;
                         else rd_cnt <= rd_cnt - 1'b1;
                RD_RESP: if (axi.r_ready) rd_state <= RD_IDLE;
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (ar_hs) begin
            ar_addr_q <= axi.ar_addr;
            ar_id_q   <= axi.ar_id;
        end
        // zero data with SLVERR outside the array
        if (rd_load) begin
            r_data_q <= rd_in_range ? mem[rd_addr[OFF_W +: IDX_W]] : '0;
            r_resp_q <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign axi.r_valid = (rd_state == RD_RESP);
    assign axi.r_data  = r_data_q;
    assign axi.r_resp  = r_resp_q;
    assign axi.r_id    = ar_id_q;
    assign axi.r_last  = (rd_state == RD_RESP);

endmodule

`default_nettype wire

/* axi_master/axi_master.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_bridge_params.svh"

module axi_master (
    input  wire logic clock,
    input  wire logic reset_n,
    rw_if.bridge      rw,
    axi_if.master     axi
);
    import mem_bridge_pkg::*;

    typedef enum logic [1:0] {
        W_IDLE,
        W_ADDR,
        W_WRITE,
        W_RESP
    } w_state_e;

    typedef enum logic [1:0] {
        R_IDLE,
        R_ADDR,
        R_READ
    } r_state_e;

    w_state_e               w_state;
    r_state_e               r_state;
    logic                   ready_q;
    logic [`DATA_WIDTH-1:0] rdata_q;
    logic                   err_q;
    logic                   start;
    logic                   w_start;
    logic                   r_start;
    logic                   aw_hs;
    logic                   w_hs;
    logic                   b_hs;
    logic                   ar_hs;
    logic                   r_done;

    assign aw_hs  = axi.aw_valid & axi.aw_ready;
    assign w_hs   = axi.w_valid & axi.w_ready;
    assign b_hs   = axi.b_valid & axi.b_ready;
    assign ar_hs  = axi.ar_valid & axi.ar_ready;
    // single beat, so last closes the read
    assign r_done = axi.r_valid & axi.r_ready & axi.r_last;

    // one transaction at a time
    // the held request is still valid during the ready pulse, skip it there
    assign start   = rw.valid & (w_state == W_IDLE) & (r_state == R_IDLE) & ~ready_q;
    assign w_start = start & (rw.req == REQ_WRITE);
    assign r_start = start & (rw.req == REQ_READ);

    // write FSM
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            w_state <= W_IDLE;
        end else begin
            case (w_state)
                W_IDLE:  if (w_start) w_state <= W_ADDR;
                W_ADDR:  if (aw_hs) w_state <= W_WRITE;
                W_WRITE: if (w_hs) w_state <= W_RESP;
                W_RESP:  if (b_hs) w_state <= W_IDLE;
                default: w_state <= W_IDLE;
            endcase
        end
    end

    // read FSM
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            r_state <= R_IDLE;
        end else begin
            case (r_state)
                R_IDLE:  if (r_start) r_state <= R_ADDR;
                R_ADDR:  if (ar_hs) r_state <= R_READ;
                R_READ:  if (r_done) r_state <= R_IDLE;
                default: r_state <= R_IDLE;
            endcase
        end
    end

    // completion pulse, a cycle after B or last R
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= b_hs | r_done;
        end
    end

    // read data and error capture
    always_ff @(posedge clock) begin
        if (r_done) begin
            rdata_q <= axi.r_data;
        end
        if (b_hs) begin
            err_q <= (axi.b_resp != RESP_OKAY);
        end else if (r_done) begin
            err_q <= (axi.r_resp != RESP_OKAY);
        end
    end

    // write channels, payload straight from the held request
    assign axi.aw_valid = (w_state == W_ADDR);
    assign axi.aw_addr  = rw.addr;
    assign axi.w_valid  = (w_state == W_WRITE);
    assign axi.w_data   = rw.wdata;
    // strobe is the requester's byte-lane mask
    assign axi.w_strb   = rw.strb;
    assign axi.w_last   = (w_state == W_WRITE);
    assign axi.b_ready  = (w_state == W_RESP);

    // read channels
    assign axi.ar_valid = (r_state == R_ADDR);
    assign axi.ar_addr  = rw.addr;
    assign axi.ar_id    = rw.id;
    assign axi.r_ready  = (r_state == R_READ);

    assign rw.ready = ready_q;
    assign rw.rdata = rdata_q;
    assign rw.err   = err_q;

endmodule

`default_nettype wire

/* hw/rw_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_bridge_params.svh"

module rw_arbiter (
    input  wire logic                    clock,
    input  wire logic                    reset_n,
    // fetch port, reads only
    input  wire logic                    fetch_valid_i,
    input  wire logic [`ADDR_WIDTH-1:0]  fetch_addr_i,
    output logic                         fetch_ready_o,
    output logic [`DATA_WIDTH-1:0]       fetch_rdata_o,
    output logic                         fetch_err_o,
    // data port
    input  wire logic                    data_valid_i,
    input  wire mem_bridge_pkg::rw_req_e data_req_i,
    input  wire logic [`ADDR_WIDTH-1:0]  data_addr_i,
    input  wire logic [`DATA_WIDTH-1:0]  data_wdata_i,
    input  wire logic [`STRB_WIDTH-1:0]  data_strb_i,
    output logic                         data_ready_o,
    output logic [`DATA_WIDTH-1:0]       data_rdata_o,
    output logic                         data_err_o,
    // towards the bridge
    rw_if.requester                      rw
);
    import mem_bridge_pkg::*;

    // grant held from pick until the bridge's ready pulse
    logic    grant_busy;
    req_id_t grant_id;
    logic    owner_data;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            grant_busy <= 1'b0;
            grant_id   <= ID_FETCH;
        end else if (!grant_busy) begin
            // data port wins a tie
            if (data_valid_i) begin
                grant_busy <= 1'b1;
                grant_id   <= ID_DATA;
            end else if (fetch_valid_i) begin
                grant_busy <= 1'b1;
                grant_id   <= ID_FETCH;
            end
        end else if (rw.ready) begin
            grant_busy <= 1'b0;
        end
    end

    assign owner_data = (grant_id == ID_DATA);

    // owner's fields onto the bridge, fetch is always a read
    assign rw.valid = grant_busy & (owner_data ? data_valid_i : fetch_valid_i);
    assign rw.req   = owner_data ? data_req_i : REQ_READ;
    assign rw.addr  = owner_data ? data_addr_i : fetch_addr_i;
    assign rw.wdata = owner_data ? data_wdata_i : '0;
    assign rw.strb  = owner_data ? data_strb_i : '0;
    assign rw.id    = grant_id;

    // completion back to the owner only, same cycle
    assign data_ready_o  = rw.ready & grant_busy & owner_data;
    assign fetch_ready_o = rw.ready & grant_busy & ~owner_data;
    assign data_rdata_o  = (grant_busy & owner_data) ? rw.rdata : '0;
    assign fetch_rdata_o = (grant_busy & ~owner_data) ? rw.rdata : '0;
    assign data_err_o    = grant_busy & owner_data & rw.err;
    assign fetch_err_o   = grant_busy & ~owner_data & rw.err;

endmodule

`default_nettype wire

/* common/axi_if.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_bridge_params.svh"

interface axi_if;
    import mem_bridge_pkg::*;

    // write address
    logic                   aw_valid;
    logic                   aw_ready;
    logic [`ADDR_WIDTH-1:0] aw_addr;

    // write data, single beat so last rides with valid
    logic                   w_valid;
    logic                   w_ready;
    logic [`DATA_WIDTH-1:0] w_data;
    logic [`STRB_WIDTH-1:0] w_strb;
    logic                   w_last;

    // write response
    logic                   b_valid;
    logic                   b_ready;
    axi_resp_e              b_resp;

    // read address
    logic                   ar_valid;
    logic                   ar_ready;
    logic [`ADDR_WIDTH-1:0] ar_addr;
    req_id_t                ar_id;

    // read data, id echoed from AR
    logic                   r_valid;
    logic                   r_ready;
    logic [`DATA_WIDTH-1:0] r_data;
    axi_resp_e              r_resp;
    req_id_t                r_id;
    logic                   r_last;

    modport master (
        output aw_valid, aw_addr, w_valid, w_data, w_strb, w_last, b_ready,
        output ar_valid, ar_addr, ar_id, r_ready,
        input  aw_ready, w_ready, b_valid, b_resp, ar_ready,
        input  r_valid, r_data, r_resp, r_id, r_last
    );

    modport slave (
        input  aw_valid, aw_addr, w_valid, w_data, w_strb, w_last, b_ready,
        input  ar_valid, ar_addr, ar_id, r_ready,
        output aw_ready, w_ready, b_valid, b_resp, ar_ready,
        output r_valid, r_data, r_resp, r_id, r_last
    );

endinterface

`default_nettype wire

/* common/rw_if.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mem_bridge_params.svh"

interface rw_if;
    import mem_bridge_pkg::*;

    // request, held stable by the arbiter until ready
    logic                   valid;
    rw_req_e                req;
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0] wdata;
    logic [`STRB_WIDTH-1:0] strb;
    req_id_t                id;

    // completion, one-cycle ready pulse
    logic                   ready;
    // rdata held until next read completes
    logic [`DATA_WIDTH-1:0] rdata;
    logic                   err;

    modport requester (
        output valid, req, addr, wdata, strb, id,
        input  ready, rdata, err
    );

    modport bridge (
        input  valid, req, addr, wdata, strb, id,
        output ready, rdata, err
    );

endinterface

`default_nettype wire

/* common/mem_bridge_pkg.sv */
`default_nettype none

`include "mem_bridge_params.svh"

package mem_bridge_pkg;

    // kind of core-side request
    typedef enum logic {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } rw_req_e;

    // AXI response codes in use here
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    // requester identity, sent as the AXI ID
    typedef logic [`ID_WIDTH-1:0] req_id_t;

    localparam req_id_t ID_FETCH = req_id_t'(0);
    localparam req_id_t ID_DATA  = req_id_t'(1);

endpackage

`default_nettype wire

/* common/mem_bridge_params.svh */
`ifndef MEM_BRIDGE_PARAMS_SVH
`define MEM_BRIDGE_PARAMS_SVH

// byte address width
`define ADDR_WIDTH 32

// data word width, one AXI beat
`define DATA_WIDTH 64

// one strobe bit per byte lane
`define STRB_WIDTH (`DATA_WIDTH / 8)

// AXI ID width, carries the requester identity
`define ID_WIDTH 4

// slave size in words, and cycles from AR handshake to R valid
`define MEM_DEPTH 256
`define READ_LATENCY 2

`endif
